//--- source/rv_pipe_consts.svh
`ifndef RV_PIPE_CONSTS_SVH
`define RV_PIPE_CONSTS_SVH

// datapath and register index widths
`define RV_XLEN        32
`define RV_REG_ADDR_W  5

`define RV_NOP         32'h0000_0013 // addi x0, x0, 0
`define RV_RESET_PC    32'h0000_0000

// ----------------------------------------------------------------------
// major opcodes, instr[6:0]
// ----------------------------------------------------------------------
`define RV_OPC_REG     7'b0110011
`define RV_OPC_IMM     7'b0010011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_JAL     7'b1101111

`endif

//--- source/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

	// alu function selected in decode
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_t;

	// branch condition, resolved in execute
	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_JAL
	} branch_t;

	// access size, same coding as funct3[1:0]
	typedef enum logic [1:0] {
		LEN_BYTE = 2'd0,
		LEN_HALF = 2'd1,
		LEN_WORD = 2'd2
	} mem_len_t;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module fetch_stage (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire  [`RV_XLEN-1:0] instr_i,
	input  wire                 stall_i,
	input  wire                 redirect_i,
	input  wire  [`RV_XLEN-1:0] redirect_pc_i,
	output logic [`RV_XLEN-1:0] instr_addr_o,
	output logic [`RV_XLEN-1:0] id_instr_o,
	output logic [`RV_XLEN-1:0] id_pc_o
);

	logic [`RV_XLEN-1:0] pc_q; // address of the word now on instr_i
	logic [`RV_XLEN-1:0] pc_next;
	logic                run_q; // low in the first cycle out of reset

	always_comb
	begin
		if (redirect_i)
			pc_next = redirect_pc_i;
		else if (stall_i || !run_q)
			pc_next = pc_q; // refetch same word
		else
			pc_next = pc_q + 32'd4;
	end

	assign instr_addr_o = pc_next; // rom registers this address

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q  <= `RV_RESET_PC;
			run_q <= 1'b0;
		end
		else
		begin
			pc_q  <= pc_next;
			run_q <= 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// IF/ID register
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			id_instr_o <= `RV_NOP;
		else if (redirect_i || !run_q)
			id_instr_o <= `RV_NOP; // wrong path or stale rom output
		else if (!stall_i)
			id_instr_o <= instr_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
			id_pc_o <= pc_q;
	end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module decode_stage import rv_pipe_pkg::*; (
	input  wire                       clk_i,
	input  wire                       reset_i,
	input  wire  [`RV_XLEN-1:0]       id_instr_i,
	input  wire  [`RV_XLEN-1:0]       id_pc_i,
	input  wire                       flush_i,
	input  wire                       wb_we_i,
	input  wire  [`RV_REG_ADDR_W-1:0] wb_rd_i,
	input  wire  [`RV_XLEN-1:0]       wb_data_i,
	output logic                      stall_o,
	output logic [`RV_XLEN-1:0]       ex_pc_o,
	output logic [`RV_XLEN-1:0]       ex_rs1_data_o,
	output logic [`RV_XLEN-1:0]       ex_rs2_data_o,
	output logic [`RV_XLEN-1:0]       ex_imm_o,
	output logic [`RV_REG_ADDR_W-1:0] ex_rs1_o,
	output logic [`RV_REG_ADDR_W-1:0] ex_rs2_o,
	output logic [`RV_REG_ADDR_W-1:0] ex_rd_o,
	output alu_op_t                   ex_alu_op_o,
	output logic                      ex_use_imm_o,
	output branch_t                   ex_branch_o,
	output logic                      ex_mem_we_o,
	output mem_len_t                  ex_mem_len_o,
	output logic                      ex_mem_sign_o,
	output logic                      ex_load_o,
	output logic                      ex_rd_we_o
);

	logic [`RV_XLEN-1:0]       regs [32];
	logic [6:0]                opcode;
	logic [2:0]                funct3;
	logic                      alt; // funct7 bit 5
	logic [`RV_REG_ADDR_W-1:0] rs1, rs2, rd;
	logic [`RV_XLEN-1:0]       imm_i, imm_s, imm_b, imm_j, imm;
	logic [`RV_XLEN-1:0]       rs1_data, rs2_data;
	alu_op_t                   alu_op;
	branch_t                   branch;
	logic                      use_imm, mem_we, load, rd_we;

	assign opcode = id_instr_i[6:0];
	assign funct3 = id_instr_i[14:12];
	assign alt    = id_instr_i[30];
	assign rs1    = id_instr_i[19:15];
	assign rs2    = id_instr_i[24:20];
	assign rd     = id_instr_i[11:7];

	assign imm_i = {{20{id_instr_i[31]}}, id_instr_i[31:20]};
	assign imm_s = {{20{id_instr_i[31]}}, id_instr_i[31:25], id_instr_i[11:7]};
	assign imm_b = {{19{id_instr_i[31]}}, id_instr_i[31], id_instr_i[7],
		id_instr_i[30:25], id_instr_i[11:8], 1'b0};
	assign imm_j = {{11{id_instr_i[31]}}, id_instr_i[31], id_instr_i[19:12],
		id_instr_i[20], id_instr_i[30:21], 1'b0};

	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000:  alu_sel = sub_sra ? ALU_SUB : ALU_ADD;
			3'b001:  alu_sel = ALU_SLL;
			3'b010:  alu_sel = ALU_SLT;
			3'b011:  alu_sel = ALU_SLTU;
			3'b100:  alu_sel = ALU_XOR;
			3'b101:  alu_sel = sub_sra ? ALU_SRA : ALU_SRL;
			3'b110:  alu_sel = ALU_OR;
			default: alu_sel = ALU_AND;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// control decode
	// ------------------------------------------------------------------
	always_comb
	begin
		alu_op  = ALU_ADD; // address math for loads and stores
		use_imm = 1'b0;
		branch  = BR_NONE;
		mem_we  = 1'b0;
		load    = 1'b0;
		rd_we   = 1'b0;
		imm     = imm_i;
		case (opcode)
			`RV_OPC_REG:
			begin
				alu_op = alu_sel(funct3, alt);
				rd_we  = 1'b1;
			end
			`RV_OPC_IMM:
			begin
				alu_op  = alu_sel(funct3, alt && funct3 == 3'b101); // only srai
				use_imm = 1'b1;
				rd_we   = 1'b1;
			end
			`RV_OPC_LOAD:
			begin
				use_imm = 1'b1;
				load    = 1'b1;
				rd_we   = 1'b1;
			end
			`RV_OPC_STORE:
			begin
				imm     = imm_s;
				use_imm = 1'b1;
				mem_we  = 1'b1;
			end
			`RV_OPC_BRANCH:
			begin
				imm = imm_b;
				case (funct3)
					3'b000:  branch = BR_EQ;
					3'b001:  branch = BR_NE;
					3'b100:  branch = BR_LT;
					3'b101:  branch = BR_GE;
					default: branch = BR_NONE; // unsigned forms not supported
				endcase
			end
			`RV_OPC_JAL:
			begin
				imm    = imm_j;
				branch = BR_JAL;
				rd_we  = 1'b1;
			end
			default: ;
		endcase
	end

	// register file, write-through from writeback
	function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_ADDR_W-1:0] a);
		if (a == '0)
			rf_read = '0;
		else if (wb_we_i && wb_rd_i == a)
			rf_read = wb_data_i;
		else
			rf_read = regs[a];
	endfunction

	always_comb
	begin
		rs1_data = rf_read(rs1);
		rs2_data = rf_read(rs2);
	end

	always_ff @(posedge clk_i)
	begin
		if (wb_we_i)
			regs[wb_rd_i] <= wb_data_i;
	end

	// load in execute feeding this instruction
	assign stall_o = ex_load_o && ex_rd_we_o && (ex_rd_o == rs1 || ex_rd_o == rs2);

	// ------------------------------------------------------------------
	// ID/EX register
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			ex_alu_op_o   <= ALU_ADD;
			ex_use_imm_o  <= 1'b0;
			ex_branch_o   <= BR_NONE;
			ex_mem_we_o   <= 1'b0;
			ex_mem_len_o  <= LEN_WORD;
			ex_mem_sign_o <= 1'b0;
			ex_load_o     <= 1'b0;
			ex_rd_we_o    <= 1'b0;
		end
		else if (flush_i || stall_o)
		begin
			ex_branch_o <= BR_NONE; // bubble
			ex_mem_we_o <= 1'b0;
			ex_load_o   <= 1'b0;
			ex_rd_we_o  <= 1'b0;
		end
		else
		begin
			ex_alu_op_o   <= alu_op;
			ex_use_imm_o  <= use_imm;
			ex_branch_o   <= branch;
			ex_mem_we_o   <= mem_we;
			ex_mem_len_o  <= mem_len_t'(funct3[1:0]);
			ex_mem_sign_o <= !funct3[2];
			ex_load_o     <= load;
			ex_rd_we_o    <= rd_we && rd != '0;
		end
	end

	always_ff @(posedge clk_i)
	begin
		ex_pc_o       <= id_pc_i;
		ex_rs1_data_o <= rs1_data;
		ex_rs2_data_o <= rs2_data;
		ex_imm_o      <= imm;
		ex_rs1_o      <= rs1;
		ex_rs2_o      <= rs2;
		ex_rd_o       <= rd;
	end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module execute_stage import rv_pipe_pkg::*; (
	input  wire                       clk_i,
	input  wire                       reset_i,
	input  wire  [`RV_XLEN-1:0]       ex_pc_i,
	input  wire  [`RV_XLEN-1:0]       ex_rs1_data_i,
	input  wire  [`RV_XLEN-1:0]       ex_rs2_data_i,
	input  wire  [`RV_XLEN-1:0]       ex_imm_i,
	input  wire  [`RV_REG_ADDR_W-1:0] ex_rs1_i,
	input  wire  [`RV_REG_ADDR_W-1:0] ex_rs2_i,
	input  wire  [`RV_REG_ADDR_W-1:0] ex_rd_i,
	input  wire  alu_op_t             ex_alu_op_i,
	input  wire                       ex_use_imm_i,
	input  wire  branch_t             ex_branch_i,
	input  wire                       ex_mem_we_i,
	input  wire  mem_len_t            ex_mem_len_i,
	input  wire                       ex_mem_sign_i,
	input  wire                       ex_load_i,
	input  wire                       ex_rd_we_i,
	input  wire                       wb_we_i,
	input  wire  [`RV_REG_ADDR_W-1:0] wb_rd_i,
	input  wire  [`RV_XLEN-1:0]       wb_data_i,
	output logic                      redirect_o,
	output logic [`RV_XLEN-1:0]       redirect_pc_o,
	output logic [`RV_XLEN-1:0]       data_addr_o,
	output logic [`RV_XLEN-1:0]       data_o,
	output logic                      data_we_o,
	output logic [3:0]                data_mask_o,
	output logic [`RV_XLEN-1:0]       mem_result_o,
	output logic [`RV_REG_ADDR_W-1:0] mem_rd_o,
	output logic                      mem_rd_we_o,
	output logic                      mem_load_o,
	output mem_len_t                  mem_len_o,
	output logic                      mem_sign_o
);

	logic [`RV_XLEN-1:0] op_a, rs2_val, op_b, alu_res;
	logic                lt_s, taken;

	// youngest producer wins, a load in EX/MEM has no data yet
	function automatic logic [`RV_XLEN-1:0] forward(
		input logic [`RV_REG_ADDR_W-1:0] rs,
		input logic [`RV_XLEN-1:0]       id_val);
		if (mem_rd_we_o && !mem_load_o && mem_rd_o == rs)
			forward = mem_result_o;
		else if (wb_we_i && wb_rd_i == rs)
			forward = wb_data_i;
		else
			forward = id_val;
	endfunction

	always_comb
	begin
		op_a    = forward(ex_rs1_i, ex_rs1_data_i);
		rs2_val = forward(ex_rs2_i, ex_rs2_data_i);
	end

	assign op_b = ex_use_imm_i ? ex_imm_i : rs2_val;

	// ------------------------------------------------------------------
	// alu
	// ------------------------------------------------------------------
	always_comb
	begin
		case (ex_alu_op_i)
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_AND:  alu_res = op_a & op_b;
			ALU_OR:   alu_res = op_a | op_b;
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
			default:  alu_res = op_a + op_b;
		endcase
	end

	// branch compare on register operands, never the immediate
	assign lt_s = $signed(op_a) < $signed(rs2_val);

	always_comb
	begin
		case (ex_branch_i)
			BR_EQ:   taken = op_a == rs2_val;
			BR_NE:   taken = op_a != rs2_val;
			BR_LT:   taken = lt_s;
			BR_GE:   taken = !lt_s;
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect_o    = taken;
	assign redirect_pc_o = ex_pc_i + ex_imm_i;

	// data memory request
	assign data_addr_o = alu_res;
	assign data_o      = rs2_val; // low lanes, no shift by address
	assign data_we_o   = ex_mem_we_i;

	always_comb
	begin
		case (ex_mem_len_i)
			LEN_BYTE: data_mask_o = 4'b0001;
			LEN_HALF: data_mask_o = 4'b0011;
			default:  data_mask_o = 4'b1111;
		endcase
	end

	// ------------------------------------------------------------------
	// EX/MEM register
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			mem_rd_we_o <= 1'b0;
			mem_load_o  <= 1'b0;
			mem_len_o   <= LEN_WORD;
			mem_sign_o  <= 1'b0;
		end
		else
		begin
			mem_rd_we_o <= ex_rd_we_i;
			mem_load_o  <= ex_load_i;
			mem_len_o   <= ex_mem_len_i;
			mem_sign_o  <= ex_mem_sign_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		mem_result_o <= (ex_branch_i == BR_JAL) ? ex_pc_i + 32'd4 : alu_res; // link
		mem_rd_o     <= ex_rd_i;
	end

endmodule

`default_nettype wire

//--- source/writeback_stage.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module writeback_stage import rv_pipe_pkg::*; (
	input  wire                       clk_i,
	input  wire                       reset_i,
	input  wire  [`RV_XLEN-1:0]       data_i,
	input  wire  [`RV_XLEN-1:0]       mem_result_i,
	input  wire  [`RV_REG_ADDR_W-1:0] mem_rd_i,
	input  wire                       mem_rd_we_i,
	input  wire                       mem_load_i,
	input  wire  mem_len_t            mem_len_i,
	input  wire                       mem_sign_i,
	output logic                      wb_we_o,
	output logic [`RV_REG_ADDR_W-1:0] wb_rd_o,
	output logic [`RV_XLEN-1:0]       wb_data_o
);

	logic [`RV_XLEN-1:0] result_q;
	logic [`RV_XLEN-1:0] word_q; // read word from data memory
	logic                load_q;
	mem_len_t            len_q;
	logic                sign_q;

	// MEM/WB register
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			wb_we_o <= 1'b0;
			load_q  <= 1'b0;
			len_q   <= LEN_WORD;
			sign_q  <= 1'b0;
		end
		else
		begin
			wb_we_o <= mem_rd_we_i;
			load_q  <= mem_load_i;
			len_q   <= mem_len_i;
			sign_q  <= mem_sign_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		wb_rd_o  <= mem_rd_i;
		result_q <= mem_result_i;
		word_q   <= data_i;
	end

	always_comb
	begin
		if (!load_q)
			wb_data_o = result_q;
		else
		begin
			case (len_q)
				LEN_BYTE: wb_data_o = {{(`RV_XLEN-8){sign_q & word_q[7]}}, word_q[7:0]};
				LEN_HALF: wb_data_o = {{(`RV_XLEN-16){sign_q & word_q[15]}}, word_q[15:0]};
				default:  wb_data_o = word_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/rv_pipe_top.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module rv_pipe_top import rv_pipe_pkg::*; (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire  [`RV_XLEN-1:0] instr_i,
	input  wire  [`RV_XLEN-1:0] data_i,
	output logic [`RV_XLEN-1:0] instr_addr_o,
	output logic [`RV_XLEN-1:0] data_addr_o,
	output logic [`RV_XLEN-1:0] data_o,
	output logic                data_we_o,
	output logic [3:0]          data_mask_o
);

	// IF/ID and hazard control
	logic [`RV_XLEN-1:0]       id_instr, id_pc;
	logic                      stall, redirect;
	logic [`RV_XLEN-1:0]       redirect_pc;

	// ID/EX
	logic [`RV_XLEN-1:0]       ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
	logic [`RV_REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
	alu_op_t                   ex_alu_op;
	branch_t                   ex_branch;
	mem_len_t                  ex_mem_len;
	logic                      ex_use_imm, ex_mem_we, ex_mem_sign, ex_load, ex_rd_we;

	// EX/MEM and writeback
	logic [`RV_XLEN-1:0]       mem_result, wb_data;
	logic [`RV_REG_ADDR_W-1:0] mem_rd, wb_rd;
	mem_len_t                  mem_len;
	logic                      mem_rd_we, mem_load, mem_sign, wb_we;

	fetch_stage u_fetch (
		.clk_i, .reset_i, .instr_i, .instr_addr_o,
		.stall_i(stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.id_instr_o(id_instr), .id_pc_o(id_pc)
	);

	decode_stage u_decode (
		.clk_i, .reset_i, .id_instr_i(id_instr), .id_pc_i(id_pc), .flush_i(redirect),
		.wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data), .stall_o(stall),
		.ex_pc_o(ex_pc), .ex_rs1_data_o(ex_rs1_data), .ex_rs2_data_o(ex_rs2_data),
		.ex_imm_o(ex_imm), .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
		.ex_alu_op_o(ex_alu_op), .ex_use_imm_o(ex_use_imm), .ex_branch_o(ex_branch),
		.ex_mem_we_o(ex_mem_we), .ex_mem_len_o(ex_mem_len), .ex_mem_sign_o(ex_mem_sign),
		.ex_load_o(ex_load), .ex_rd_we_o(ex_rd_we)
	);

	execute_stage u_execute (
		.clk_i, .reset_i, .ex_pc_i(ex_pc), .ex_rs1_data_i(ex_rs1_data),
		.ex_rs2_data_i(ex_rs2_data), .ex_imm_i(ex_imm), .ex_rs1_i(ex_rs1),
		.ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd), .ex_alu_op_i(ex_alu_op),
		.ex_use_imm_i(ex_use_imm), .ex_branch_i(ex_branch), .ex_mem_we_i(ex_mem_we),
		.ex_mem_len_i(ex_mem_len), .ex_mem_sign_i(ex_mem_sign), .ex_load_i(ex_load),
		.ex_rd_we_i(ex_rd_we), .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
		.redirect_o(redirect), .redirect_pc_o(redirect_pc),
		.data_addr_o, .data_o, .data_we_o, .data_mask_o,
		.mem_result_o(mem_result), .mem_rd_o(mem_rd), .mem_rd_we_o(mem_rd_we),
		.mem_load_o(mem_load), .mem_len_o(mem_len), .mem_sign_o(mem_sign)
	);

	writeback_stage u_writeback (
		.clk_i, .reset_i, .data_i,
		.mem_result_i(mem_result), .mem_rd_i(mem_rd), .mem_rd_we_i(mem_rd_we),
		.mem_load_i(mem_load), .mem_len_i(mem_len), .mem_sign_i(mem_sign),
		.wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
	parameter int period = 40
) (
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0; // first rising edge at half a period
		forever
			#(period / 2) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

//--- tests/rv_pipe_properties.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module rv_pipe_properties (
	input wire                clk_i,
	input wire                reset_i,
	input wire [`RV_XLEN-1:0] instr_addr_i,
	input wire [`RV_XLEN-1:0] data_addr_i,
	input wire                data_we_i,
	input wire [3:0]          data_mask_i
);

	int unsigned fail_count = 0; // read by the testbench at the end

	// no write leaves the core while reset is low
	reset_quiet: assert property (@(posedge clk_i) !reset_i |-> !data_we_i)
	else
	begin
		$error("data memory write requested during reset");
		fail_count++;
	end

	// legal mask, and the address fits the access size
	mask_legal: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_we_i |-> (data_mask_i == 4'b0001 ||
			(data_mask_i == 4'b0011 && data_addr_i[0] == 1'b0) ||
			(data_mask_i == 4'b1111 && data_addr_i[1:0] == 2'b00)))
	else
	begin
		$error("store byte mask %b does not fit address %h", data_mask_i, data_addr_i);
		fail_count++;
	end

	fetch_aligned: assert property (@(posedge clk_i) disable iff (!reset_i)
		instr_addr_i[1:0] == 2'b00)
	else
	begin
		$error("instruction address %h is not word aligned", instr_addr_i);
		fail_count++;
	end

endmodule

`default_nettype wire

//--- tests/rv_pipe_tb.sv
`default_nettype none
`include "rv_pipe_consts.svh"

module rv_pipe_tb;

	localparam int clk_period = 40;
	localparam int max_cycles = 40; // reset release to the final store

	typedef enum logic [4:0] {
		K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLTU, K_SLL, K_SRL, K_SRA,
		K_ADDI, K_XORI, K_SLLI, K_LB, K_LBU, K_LH, K_LHU, K_SB, K_SH,
		K_BEQ, K_BNE, K_BLT, K_BGE, K_JAL
	} kind_t;

	typedef struct packed {
		kind_t       kind;
		logic        open_a; // operand taken from the generator
		logic        open_b;
		logic [31:0] a;
		logic [31:0] b;
	} row_t;

	logic                clk_i;
	logic                reset_i;
	logic [`RV_XLEN-1:0] instr_i;
	logic [`RV_XLEN-1:0] data_i;
	logic [`RV_XLEN-1:0] instr_addr_o;
	logic [`RV_XLEN-1:0] data_addr_o;
	logic [`RV_XLEN-1:0] data_o;
	logic                data_we_o;
	logic [3:0]          data_mask_o;

	logic [31:0] rom [64];
	logic [31:0] ram [16];
	row_t        rows [$];
	logic [31:0] rng_state = 32'd65203;
	int          pass_count = 0;
	int          fail_count = 0;
	int          errors = 0;

	// requests seen at the falling edge, served after the rising edge
	logic [31:0] fetch_addr = '0;
	logic [31:0] req_addr = '0;
	logic [31:0] req_data = '0;
	logic [3:0]  req_mask = '0;
	logic        req_we = 1'b0;
	logic        store_seen = 1'b0;
	logic [31:0] stored_word = '0;

	tb_clock_gen #(.period(clk_period)) clk_gen (.clk_o(clk_i));

	rv_pipe_top dut (
		.clk_i, .reset_i, .instr_i, .data_i,
		.instr_addr_o, .data_addr_o, .data_o, .data_we_o, .data_mask_o
	);

	bind rv_pipe_top rv_pipe_properties props (
		.clk_i, .reset_i, .instr_addr_i(instr_addr_o), .data_addr_i(data_addr_o),
		.data_we_i(data_we_o), .data_mask_i(data_mask_o)
	);

	// ----------------------------------------------------------------------
	// memory models
	// ----------------------------------------------------------------------
	always @(negedge clk_i)
	begin
		fetch_addr = instr_addr_o;
		req_addr   = data_addr_o;
		req_data   = data_o;
		req_mask   = data_mask_o;
		req_we     = data_we_o;
	end

	always @(posedge clk_i)
	begin
		#1;
		if (req_we)
		begin
			for (int i = 0; i < 4; i++)
				if (req_mask[i])
					ram[req_addr[5:2]][8*i +: 8] = req_data[8*i +: 8];
			if (req_addr == 32'd8)
			begin
				store_seen  = 1'b1;
				stored_word = ram[2];
			end
		end
		instr_i = rom[fetch_addr[7:2]]; // one cycle read latency
		data_i  = ram[req_addr[5:2]];
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		xorshift32 = y ^ (y << 5);
	endfunction

	// distinct word for every byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		fill_word = (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
	endfunction

	// ----------------------------------------------------------------------
	// instruction encoders
	// ----------------------------------------------------------------------
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		enc_r = {f7, rs2, rs1, f3, rd, `RV_OPC_REG};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		enc_i = {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
	endfunction

	function automatic logic [2:0] funct3_of(input kind_t k);
		case (k)
			K_SLL, K_SLLI, K_LH, K_SH, K_BNE: funct3_of = 3'b001;
			K_SLT:                            funct3_of = 3'b010;
			K_SLTU:                           funct3_of = 3'b011;
			K_XOR, K_XORI, K_LBU, K_BLT:      funct3_of = 3'b100;
			K_SRL, K_SRA, K_LHU, K_BGE:       funct3_of = 3'b101;
			K_OR:                             funct3_of = 3'b110;
			K_AND:                            funct3_of = 3'b111;
			default:                          funct3_of = 3'b000;
		endcase
	endfunction

	// every program ends with a store to address 8
	task automatic build_program(input kind_t k, input logic [31:0] b);
		logic [31:0] sw_x3;
		logic [11:0] imm;
		sw_x3 = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
		imm   = (k == K_SLLI) ? {7'b0, b[4:0]} : b[11:0];
		for (int i = 0; i < 64; i++)
			rom[i] = `RV_NOP;
		rom[0] = enc_i(12'd0, 5'd0, 3'b010, 5'd1, `RV_OPC_LOAD); // lw x1, 0(x0)
		rom[1] = enc_i(12'd4, 5'd0, 3'b010, 5'd2, `RV_OPC_LOAD); // lw x2, 4(x0)
		case (k)
			K_ADDI, K_XORI, K_SLLI:
			begin
				rom[2] = enc_i(imm, 5'd1, funct3_of(k), 5'd3, `RV_OPC_IMM);
				rom[3] = sw_x3;
			end
			K_LB, K_LBU, K_LH, K_LHU:
			begin
				rom[2] = enc_i(12'd0, 5'd0, funct3_of(k), 5'd3, `RV_OPC_LOAD);
				rom[3] = sw_x3;
			end
			K_SB, K_SH:
			begin
				rom[2] = enc_s(12'd12, 5'd2, 5'd0, funct3_of(k));
				rom[3] = enc_i(12'd12, 5'd0, 3'b010, 5'd3, `RV_OPC_LOAD); // read back
				rom[4] = sw_x3;
			end
			K_BEQ, K_BNE, K_BLT, K_BGE:
			begin
				rom[2] = enc_i(12'd1, 5'd0, 3'b000, 5'd3, `RV_OPC_IMM);
				rom[3] = enc_b(13'd8, 5'd2, 5'd1, funct3_of(k));
				rom[4] = enc_i(12'd2, 5'd0, 3'b000, 5'd3, `RV_OPC_IMM); // skipped if taken
				rom[5] = sw_x3;
			end
			K_JAL:
			begin
				rom[2] = enc_j(21'd8, 5'd5);
				rom[3] = enc_i(12'd0, 5'd0, 3'b000, 5'd5, `RV_OPC_IMM);
				rom[4] = enc_s(12'd8, 5'd5, 5'd0, 3'b010);
			end
			default:
			begin
				rom[2] = enc_r((k == K_SUB || k == K_SRA) ? 7'h20 : 7'h00,
					5'd2, 5'd1, funct3_of(k), 5'd3);
				rom[3] = sw_x3;
			end
		endcase
	endtask

	// word expected at address 8 from the instruction set rules
	function automatic logic [31:0] expect_value(input kind_t k, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] imm;
		imm = {{20{b[11]}}, b[11:0]};
		case (k)
			K_ADD:   expect_value = a + b;
			K_SUB:   expect_value = a - b;
			K_AND:   expect_value = a & b;
			K_OR:    expect_value = a | b;
			K_XOR:   expect_value = a ^ b;
			K_SLT:   expect_value = {31'b0, $signed(a) < $signed(b)};
			K_SLTU:  expect_value = {31'b0, a < b};
			K_SLL:   expect_value = a << b[4:0];
			K_SRL:   expect_value = a >> b[4:0];
			K_SRA:   expect_value = $signed(a) >>> b[4:0];
			K_ADDI:  expect_value = a + imm;
			K_XORI:  expect_value = a ^ imm;
			K_SLLI:  expect_value = a << b[4:0];
			K_LB:    expect_value = {{24{a[7]}}, a[7:0]};
			K_LBU:   expect_value = {24'b0, a[7:0]};
			K_LH:    expect_value = {{16{a[15]}}, a[15:0]};
			K_LHU:   expect_value = {16'b0, a[15:0]};
			K_SB:    expect_value = (fill_word(32'd12) & 32'hFFFF_FF00) | (b & 32'h0000_00FF);
			K_SH:    expect_value = (fill_word(32'd12) & 32'hFFFF_0000) | (b & 32'h0000_FFFF);
			K_BEQ:   expect_value = (a == b) ? 32'd1 : 32'd2; // 1 when taken
			K_BNE:   expect_value = (a != b) ? 32'd1 : 32'd2;
			K_BLT:   expect_value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd2;
			K_BGE:   expect_value = ($signed(a) >= $signed(b)) ? 32'd1 : 32'd2;
			default: expect_value = 32'd12; // jal at 8 links 12
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic add_row(input kind_t k, input logic open_a, input logic open_b,
		input logic [31:0] a, input logic [31:0] b);
		row_t r;
		r.kind   = k;
		r.open_a = open_a;
		r.open_b = open_b;
		r.a      = a;
		r.b      = b;
		rows.push_back(r);
	endtask

	task automatic run_row(input int idx);
		row_t        r;
		logic [31:0] a;
		logic [31:0] b;
		int          cycles;
		int          errors_before;
		r = rows[idx];
		a = r.a;
		b = r.b;
		if (r.open_a)
		begin
			rng_state = xorshift32(rng_state);
			a = rng_state;
		end
		if (r.open_b)
		begin
			rng_state = xorshift32(rng_state);
			b = rng_state;
		end
		errors_before = errors;
		@(posedge clk_i);
		#1 reset_i = 1'b0;
		@(negedge clk_i);
		build_program(r.kind, b);
		for (int i = 0; i < 16; i++)
			ram[i] = fill_word(i * 4);
		ram[0] = a;
		ram[1] = b;
		store_seen = 1'b0;
		repeat (2) @(posedge clk_i);
		#1 reset_i = 1'b1;
		cycles = 0;
		while (!store_seen && cycles < max_cycles)
		begin
			@(posedge clk_i);
			cycles++;
		end
		if (!store_seen)
		begin
			$display("no store to address 8 within %0d cycles", max_cycles);
			errors++;
		end
		else
			check_value("stored_word", stored_word, expect_value(r.kind, a, b));
		if (errors == errors_before)
			pass_count++;
		else
			fail_count++;
		$display("test %0d %s a=%h b=%h %s", idx, r.kind.name(), a, b,
			(errors == errors_before) ? "passed" : "failed");
	endtask

	// ----------------------------------------------------------------------
	// test table and main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		reset_i = 1'b0;
		instr_i = `RV_NOP;
		data_i  = '0;
		add_row(K_ADD,  1, 1, 0, 0);
		add_row(K_ADD,  0, 0, 32'h7FFF_FFFF, 32'h0000_0001); // wraps
		add_row(K_SUB,  1, 1, 0, 0);
		add_row(K_AND,  1, 1, 0, 0);
		add_row(K_OR,   1, 1, 0, 0);
		add_row(K_XOR,  1, 1, 0, 0);
		add_row(K_SLT,  1, 1, 0, 0);
		add_row(K_SLT,  0, 0, 32'hFFFF_FFF0, 32'h0000_0005);
		add_row(K_SLTU, 1, 1, 0, 0);
		add_row(K_SLTU, 0, 0, 32'hFFFF_FFF0, 32'h0000_0005);
		add_row(K_SLL,  1, 1, 0, 0);
		add_row(K_SRL,  1, 1, 0, 0);
		add_row(K_SRA,  1, 1, 0, 0);
		add_row(K_SRA,  0, 0, 32'h8000_1234, 32'h0000_0023); // shamt 3
		add_row(K_ADDI, 1, 0, 0, 32'hFFFF_FFFD); // -3
		add_row(K_XORI, 1, 0, 0, 32'h0000_05A5);
		add_row(K_SLLI, 1, 0, 0, 32'h0000_0007);
		add_row(K_LB,   0, 0, 32'h1234_5680, 0);
		add_row(K_LBU,  0, 0, 32'h1234_5680, 0);
		add_row(K_LH,   0, 0, 32'hABCD_9F01, 0);
		add_row(K_LHU,  0, 0, 32'hABCD_9F01, 0);
		add_row(K_LB,   1, 0, 0, 0);
		add_row(K_SB,   1, 1, 0, 0);
		add_row(K_SH,   1, 1, 0, 0);
		add_row(K_BEQ,  0, 0, 32'h0000_0055, 32'h0000_0055);
		add_row(K_BEQ,  1, 1, 0, 0);
		add_row(K_BNE,  0, 0, 32'h0000_0055, 32'h0000_0055);
		add_row(K_BNE,  1, 1, 0, 0);
		add_row(K_BLT,  0, 0, 32'hFFFF_FFFF, 32'h0000_0001);
		add_row(K_BGE,  0, 0, 32'hFFFF_FFFF, 32'h0000_0001);
		add_row(K_BLT,  1, 1, 0, 0);
		add_row(K_BGE,  1, 1, 0, 0);
		add_row(K_JAL,  1, 1, 0, 0);
		for (int i = 0; i < rows.size(); i++)
			run_row(i);
		$display("%0d tests passed, %0d failed, %0d assertion failures",
			pass_count, fail_count, dut.props.fail_count);
		if (fail_count == 0 && dut.props.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog, 50 cycles per table row
	initial
	begin
		#1;
		#(rows.size() * 50 * clk_period);
		$display("watchdog expired before all tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_pipe.f
+incdir+source
source/rv_pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/rv_pipe_top.sv
tests/tb_clock_gen.sv
tests/rv_pipe_properties.sv
tests/rv_pipe_tb.sv
